// ==== hdl/expand_conv.sv ====
`timescale 1ns/1ps

module expand_conv #(
	parameter int KERNEL_DIM = 3
) (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            en,
	input  logic [fire_pkg::WIDTH-1:0]                      ifm,
	output logic                                            sample,
	output logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0]     result,
	output logic                                            layer_end
);

	localparam int W = fire_pkg::WIDTH;
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * fire_pkg::CHIN;
	localparam int TAP_W = (TAPS > 1) ? $clog2(TAPS) : 1;
	// Pixels per layer
	localparam int NPIX = fire_pkg::WOUT * fire_pkg::WOUT;
	localparam int PIX_W = (NPIX > 1) ? $clog2(NPIX) : 1;

	logic                          accept;
	logic [TAP_W-1:0]              tap_cnt;
	logic [PIX_W-1:0]              pix_cnt;
	logic                          last_tap;
	logic                          clr_pulse;
	logic                          done;
	logic                          en_d;
	logic signed [W-1:0]           ifm_d;
	logic [fire_pkg::DSP_NO*W-1:0] ker_flat;

	// Inputs past the last window are dropped
	assign accept = en && !done;

	////////////////////////////////////////////////////////////////////////////
	// Tap counter, ROM address and window restart
	////////////////////////////////////////////////////////////////////////////

	// Counter is the ROM address of the tap on ifm this cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tap_cnt <= '0;
			pix_cnt <= '0;
			last_tap <= 1'b0;
			done <= 1'b0;
		end else begin
			last_tap <= 1'b0;
			if (accept) begin
				if (tap_cnt == TAP_W'(TAPS - 1)) begin
					tap_cnt <= '0;
					last_tap <= 1'b1;
					pix_cnt <= pix_cnt + 1'b1;
					// Last window of the layer
					if (pix_cnt == PIX_W'(NPIX - 1))
						done <= 1'b1;
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
				end
			end
		end
	end

	// Enable and restart, delayed to meet the ROM output
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_d <= 1'b0;
			clr_pulse <= 1'b0;
		end else begin
			en_d <= accept;
			clr_pulse <= last_tap;
		end
	end

	// Value in step with en_d
	always_ff @(posedge clk) begin
		ifm_d <= ifm;
	end

	weight_rom #(
		.KERNEL_DIM(KERNEL_DIM)
	) u_rom (
		.clk (clk),
		.addr(tap_cnt),
		.ker (ker_flat)
	);

	////////////////////////////////////////////////////////////////////////////
	// MAC lanes, bias, ReLU and requantize
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < fire_pkg::DSP_NO; g++) begin : g_lane
		localparam logic signed [fire_pkg::ACC_W-1:0] BIAS =
			fire_pkg::bias_value(KERNEL_DIM, g);
		logic signed [fire_pkg::ACC_W-1:0] acc;
		logic signed [fire_pkg::ACC_W-1:0] biased;
		logic [W-1:0] res_q;

		mac u_mac (
			.clk     (clk),
			.rst_n   (rst_n),
			.clr     (clr_pulse),
			.layer_en(en_d),
			.pix     (ifm_d),
			.ker     (ker_flat[g*W +: W]),
			.mul_out (acc)
		);

		// Window sum is complete while clr_pulse is high
		assign biased = acc + BIAS;

		// Negative goes to zero, else bits 28..14 under a zero sign
		always_ff @(posedge clk) begin
			if (clr_pulse) begin
				if (biased[fire_pkg::ACC_W-1])
					res_q <= '0;
				else
					res_q <= {1'b0, biased[fire_pkg::FRAC+W-2:fire_pkg::FRAC]};
			end
		end

		assign result[g*W +: W] = res_q;
	end

	////////////////////////////////////////////////////////////////////////////
	// Sample strobe and layer end
	////////////////////////////////////////////////////////////////////////////

	// Sample lines up with the registered result
	// Layer end rises together with the last sample
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample <= 1'b0;
			layer_end <= 1'b0;
		end else begin
			sample <= clr_pulse;
			if (clr_pulse && done)
				layer_end <= 1'b1;
		end
	end

	// Counter never passes the window length
	a_tap_range: assert property (@(posedge clk) disable iff (!rst_n)
		tap_cnt < TAP_W'(TAPS - 1) || tap_cnt == TAP_W'(TAPS - 1));

endmodule

// ==== hdl/fire_concat.sv ====
`timescale 1ns/1ps

module fire_concat (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            sample_1x1,
	input  logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0]     result_1x1,
	input  logic                                            end_1x1,
	input  logic                                            sample_3x3,
	input  logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0]     result_3x3,
	input  logic                                            end_3x3,
	input  logic                                            ram_feedback,
	output logic                                            ofm_valid,
	output logic [fire_pkg::OUT_CH*fire_pkg::WIDTH-1:0]     ofm,
	output logic                                            finish
);

	localparam int VW = fire_pkg::DSP_NO * fire_pkg::WIDTH;

	// Index 0 is the 1x1 branch, index 1 the 3x3 branch
	logic [1:0]    push;
	logic [1:0]    ends;
	logic [VW-1:0] din [2];
	logic [VW-1:0] q_data [2][2];
	logic [1:0]    wr_ptr;
	logic [1:0]    rd_ptr;
	logic [1:0]    q_cnt [2];
	logic [1:0]    avail;
	logic [VW-1:0] head [2];
	logic          pop;
	logic          fb_seen;

	assign push = {sample_3x3, sample_1x1};
	assign ends = {end_3x3, end_1x1};
	assign din[0] = result_1x1;
	assign din[1] = result_3x3;

	// Branch ready with a queued pixel or one arriving this cycle
	assign avail[0] = (q_cnt[0] != 2'd0) || push[0];
	assign avail[1] = (q_cnt[1] != 2'd0) || push[1];

	// Oldest pixel of each branch, straight from the input when the queue is empty
	assign head[0] = (q_cnt[0] != 2'd0) ? q_data[0][rd_ptr[0]] : din[0];
	assign head[1] = (q_cnt[1] != 2'd0) ? q_data[1][rd_ptr[1]] : din[1];

	// Pair ready once both branches hold a pixel
	assign pop = avail[0] && avail[1];

	////////////////////////////////////////////////////////////////////////////
	// Two-deep pending queues
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt[0] <= '0;
			q_cnt[1] <= '0;
		end else begin
			for (int b = 0; b < 2; b++) begin
				if (push[b])
					wr_ptr[b] <= ~wr_ptr[b];
				if (pop)
					rd_ptr[b] <= ~rd_ptr[b];
				q_cnt[b] <= q_cnt[b] + 2'(push[b]) - 2'(pop);
			end
		end
	end

	// Queue storage
	always_ff @(posedge clk) begin
		for (int b = 0; b < 2; b++) begin
			if (push[b])
				q_data[b][wr_ptr[b]] <= din[b];
		end
	end

	// Concatenated output, 1x1 words low
	always_ff @(posedge clk) begin
		if (pop)
			ofm <= {head[1], head[0]};
	end

	////////////////////////////////////////////////////////////////////////////
	// Valid strobe and finish flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ofm_valid <= 1'b0;
			fb_seen <= 1'b0;
		end else begin
			ofm_valid <= pop;
			// Sticky write-back seen
			if (ram_feedback)
				fb_seen <= 1'b1;
		end
	end

	assign finish = end_1x1 && end_3x3 && !fb_seen;

	// A branch may lead by two pixels at most, and stays quiet once ended
	for (genvar b = 0; b < 2; b++) begin : g_chk
		a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
			push[b] |-> (q_cnt[b] != 2'd2 || pop));
		a_quiet_end: assert property (@(posedge clk) disable iff (!rst_n)
			ends[b] |=> !push[b]);
	end

endmodule

// ==== hdl/fire_expand.sv ====
`timescale 1ns/1ps

module fire_expand (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            en_1x1,
	input  logic [fire_pkg::WIDTH-1:0]                      ifm_1x1,
	input  logic                                            en_3x3,
	input  logic [fire_pkg::WIDTH-1:0]                      ifm_3x3,
	input  logic                                            ram_feedback,
	output logic                                            ofm_valid,
	output logic [fire_pkg::OUT_CH*fire_pkg::WIDTH-1:0]     ofm,
	output logic                                            finish
);

	// Branch results toward the combiner
	logic                                        sample_1x1;
	logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0] result_1x1;
	logic                                        end_1x1;
	logic                                        sample_3x3;
	logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0] result_3x3;
	logic                                        end_3x3;

	////////////////////////////////////////////////////////////////////////////
	// Expand branches side by side
	////////////////////////////////////////////////////////////////////////////

	// 1x1 branch
	expand_conv #(
		.KERNEL_DIM(fire_pkg::K1)
	) u_exp_1x1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.en       (en_1x1),
		.ifm      (ifm_1x1),
		.sample   (sample_1x1),
		.result   (result_1x1),
		.layer_end(end_1x1)
	);

	// 3x3 branch
	expand_conv #(
		.KERNEL_DIM(fire_pkg::K3)
	) u_exp_3x3 (
		.clk      (clk),
		.rst_n    (rst_n),
		.en       (en_3x3),
		.ifm      (ifm_3x3),
		.sample   (sample_3x3),
		.result   (result_3x3),
		.layer_end(end_3x3)
	);

	// Pixel pairing and finish
	fire_concat u_concat (
		.clk         (clk),
		.rst_n       (rst_n),
		.sample_1x1  (sample_1x1),
		.result_1x1  (result_1x1),
		.end_1x1     (end_1x1),
		.sample_3x3  (sample_3x3),
		.result_3x3  (result_3x3),
		.end_3x3     (end_3x3),
		.ram_feedback(ram_feedback),
		.ofm_valid   (ofm_valid),
		.ofm         (ofm),
		.finish      (finish)
	);

endmodule

// ==== hdl/fire_pkg.sv ====
package fire_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word sizes and fixed-point format
	////////////////////////////////////////////////////////////////////////////

	// Feature and weight word
	localparam int WIDTH = 16;
	// Accumulator and bias word
	localparam int ACC_W = 32;
	// Requantize shift, output is bits 28..14
	localparam int FRAC = 14;

	// Lanes per expand branch
	localparam int DSP_NO = 4;
	// Input channels per window position
	localparam int CHIN = 4;
	// Output map width, a layer is WOUT*WOUT pixels
	localparam int WOUT = 4;

	// Window sizes of the two branches
	localparam int K1 = 1;
	localparam int K3 = 3;
	// Concatenated output channels
	localparam int OUT_CH = 2 * DSP_NO;

	////////////////////////////////////////////////////////////////////////////
	// Fixed weight and bias rules
	////////////////////////////////////////////////////////////////////////////

	// Small signed weight in -7..7 from a mixing rule
	function automatic logic signed [WIDTH-1:0] kernel_weight(int k, int lane, int tap);
		int mix;
		mix = (tap * 7 + lane * 11 + k * 3) % 15;
		return WIDTH'(mix - 7);
	endfunction

	// Per-lane bias, signed, in accumulator units
	function automatic logic signed [ACC_W-1:0] bias_value(int k, int lane);
		int b;
		b = (lane * 2 - 3) * (k + 1) * 4096;
		return ACC_W'(b);
	endfunction

endpackage

// ==== hdl/mac.sv ====
`timescale 1ns/1ps

module mac (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    clr,
	input  logic                                    layer_en,
	input  logic signed [fire_pkg::WIDTH-1:0]       pix,
	input  logic signed [fire_pkg::WIDTH-1:0]       ker,
	output logic signed [fire_pkg::ACC_W-1:0]       mul_out
);

	logic signed [fire_pkg::ACC_W-1:0] prod;
	logic signed [fire_pkg::ACC_W-1:0] acc;

	// Full-width signed product
	assign prod = pix * ker;

	// Accumulate while enabled
	// Restart keeps the tap of this cycle, so windows can run back to back
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (clr) begin
			if (layer_en)
				acc <= prod;
			else
				acc <= '0;
		end else if (layer_en) begin
			acc <= acc + prod;
		end
	end

	assign mul_out = acc;

endmodule

// ==== hdl/weight_rom.sv ====
`timescale 1ns/1ps

module weight_rom #(
	parameter int KERNEL_DIM = 3
) (
	clk,
	addr,
	ker
);

	// Taps per window and matching address width
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * fire_pkg::CHIN;
	localparam int ADDR_W = (TAPS > 1) ? $clog2(TAPS) : 1;
	localparam int ROW_W = fire_pkg::DSP_NO * fire_pkg::WIDTH;

	input  logic              clk;
	input  logic [ADDR_W-1:0] addr;
	output logic [ROW_W-1:0]  ker;

	// One row per tap, all lanes side by side
	logic [ROW_W-1:0] rom [TAPS];

	////////////////////////////////////////////////////////////////////////////
	// Contents from the fixed weight rule
	////////////////////////////////////////////////////////////////////////////

	for (genvar t = 0; t < TAPS; t++) begin : g_tap
		for (genvar l = 0; l < fire_pkg::DSP_NO; l++) begin : g_lane
			assign rom[t][l*fire_pkg::WIDTH +: fire_pkg::WIDTH] =
				fire_pkg::kernel_weight(KERNEL_DIM, l, t);
		end
	end

	// Registered read, weights one cycle after addr
	always_ff @(posedge clk) begin
		ker <= rom[addr];
	end

endmodule

// ==== project.f ====
+incdir+tests
hdl/fire_pkg.sv
hdl/mac.sv
hdl/weight_rom.sv
hdl/expand_conv.sv
hdl/fire_concat.sv
hdl/fire_expand.sv
tests/tb_fire_expand.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module tb_fire_expand -f project.f -o sim_fire &&
	./obj_dir/sim_fire ||
	exit 1

// ==== tests/fire_model.svh ====
`ifndef FIRE_MODEL_SVH
`define FIRE_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Expected results
////////////////////////////////////////////////////////////////////////////

// Concatenated vectors, oldest pixel first
logic [fire_pkg::OUT_CH*fire_pkg::WIDTH-1:0] exp_q [$];

// ReLU cases met by the model
int relu_zero_cnt = 0;
int relu_pos_cnt = 0;

// Word compare, stops the run on the first mismatch
task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp) begin
		$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
		fail_stop();
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Branch model
////////////////////////////////////////////////////////////////////////////

// One window through all lanes of a branch
task automatic model_branch(input int k, input logic [fire_pkg::WIDTH-1:0] win [MAX_TAPS],
		output logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0] words);
	int acc;
	int taps;
	taps = k * k * fire_pkg::CHIN;
	words = '0;
	for (int l = 0; l < fire_pkg::DSP_NO; l++) begin
		// Start from the lane bias
		acc = int'(fire_pkg::bias_value(k, l));
		for (int t = 0; t < taps; t++)
			acc += int'($signed(win[t])) * int'(fire_pkg::kernel_weight(k, l, t));
		if (acc < 0) begin
			// Negative sum clamps to zero
			relu_zero_cnt++;
		end else begin
			// Drop fraction, keep 15 bits under a zero sign
			relu_pos_cnt++;
			words[l*fire_pkg::WIDTH +: fire_pkg::WIDTH] = 16'((acc >>> fire_pkg::FRAC) & 32'h7fff);
		end
	end
endtask

// Both branches of one pixel, 1x1 words low
task automatic model_pixel();
	logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0] w1;
	logic [fire_pkg::DSP_NO*fire_pkg::WIDTH-1:0] w3;
	model_branch(fire_pkg::K1, win1, w1);
	model_branch(fire_pkg::K3, win3, w3);
	exp_q.push_back({w3, w1});
endtask

`endif

// ==== tests/tb_fire_expand.sv ====
`timescale 1ns/1ps

module tb_fire_expand;

	// Derived sizes and limits
	localparam int NPIX = fire_pkg::WOUT * fire_pkg::WOUT;
	localparam int MAX_TAPS = fire_pkg::K3 * fire_pkg::K3 * fire_pkg::CHIN;
	localparam int OUT_LIMIT = 20000;
	localparam int FINISH_LIMIT = 200;

	logic                                        clk = 1'b0;
	logic                                        rst_n;
	logic                                        en_1x1;
	logic [fire_pkg::WIDTH-1:0]                  ifm_1x1;
	logic                                        en_3x3;
	logic [fire_pkg::WIDTH-1:0]                  ifm_3x3;
	logic                                        ram_feedback;
	logic                                        ofm_valid;
	logic [fire_pkg::OUT_CH*fire_pkg::WIDTH-1:0] ofm;
	logic                                        finish;

	// Taps and idle gaps of the pixel in flight
	logic [fire_pkg::WIDTH-1:0] win1 [MAX_TAPS];
	logic [fire_pkg::WIDTH-1:0] win3 [MAX_TAPS];
	logic [1:0]                 gap1 [MAX_TAPS];
	logic [1:0]                 gap3 [MAX_TAPS];

	logic [31:0]                                 lcg_state = 32'd90247;
	logic [fire_pkg::OUT_CH*fire_pkg::WIDTH-1:0] exp_vec;
	int                                          out_count = 0;

	fire_expand uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.en_1x1      (en_1x1),
		.ifm_1x1     (ifm_1x1),
		.en_3x3      (en_3x3),
		.ifm_3x3     (ifm_3x3),
		.ram_feedback(ram_feedback),
		.ofm_valid   (ofm_valid),
		.ofm         (ofm),
		.finish      (finish)
	);

	// 100 ns period
	always #50 clk = ~clk;

	`include "fire_model.svh"

	task automatic fail_stop();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Both windows drawn up front, so stream order never moves the sequence
	task automatic gen_pixel(input bit model_it);
		logic [31:0] r;
		for (int t = 0; t < MAX_TAPS; t++) begin
			r = lcg_next();
			win1[t] = r[31:16];
			gap1[t] = r[15:14];
		end
		for (int t = 0; t < MAX_TAPS; t++) begin
			r = lcg_next();
			win3[t] = r[31:16];
			gap3[t] = r[15:14];
		end
		if (model_it)
			model_pixel();
	endtask

	task automatic set_stream(input bit is_3x3, input logic en, input logic [15:0] v);
		if (is_3x3) begin
			en_3x3 <= en;
			ifm_3x3 <= v;
		end else begin
			en_1x1 <= en;
			ifm_1x1 <= v;
		end
	endtask

	// One window with idle gaps
	// With hold set the enable stays up after the last tap, so the next window can follow at once
	task automatic drive_branch(input bit is_3x3, input bit hold);
		int n;
		logic [1:0] gap;
		logic [15:0] v;
		n = is_3x3 ? MAX_TAPS : fire_pkg::K1 * fire_pkg::K1 * fire_pkg::CHIN;
		v = '0;
		for (int t = 0; t < n; t++) begin
			gap = is_3x3 ? gap3[t] : gap1[t];
			v = is_3x3 ? win3[t] : win1[t];
			repeat (gap) begin
				@(posedge clk);
				set_stream(is_3x3, 1'b0, v);
			end
			@(posedge clk);
			set_stream(is_3x3, 1'b1, v);
		end
		if (!hold) begin
			@(posedge clk);
			set_stream(is_3x3, 1'b0, v);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////////////////////

	// Outputs sampled on the falling edge
	always @(negedge clk) begin
		if (rst_n && ofm_valid) begin
			if (exp_q.size() == 0) begin
				$display("ofm_valid pulsed with no pixel left to expect");
				fail_stop();
			end else begin
				exp_vec = exp_q.pop_front();
				for (int w = 0; w < fire_pkg::OUT_CH; w++)
					check_value($sformatf("ofm[%0d]", w),
						32'(ofm[w*fire_pkg::WIDTH +: fire_pkg::WIDTH]),
						32'(exp_vec[w*fire_pkg::WIDTH +: fire_pkg::WIDTH]));
				out_count++;
			end
		end
		// Finish only once the later branch is through
		if (rst_n && finish && out_count < NPIX - 1) begin
			$display("finish rose before the last pixel of the layer");
			fail_stop();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		rst_n <= 1'b0;
		en_1x1 <= 1'b0;
		ifm_1x1 <= '0;
		en_3x3 <= 1'b0;
		ifm_3x3 <= '0;
		ram_feedback <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// Quiet outputs before any input
		@(negedge clk);
		check_value("ofm_valid", 32'(ofm_valid), 32'd0);
		check_value("finish", 32'(finish), 32'd0);

		// Full layer, both streams of a pixel side by side
		// The 3x3 stream is the longer one and keeps its enable between windows
		for (int p = 0; p < NPIX; p++) begin
			gen_pixel(1'b1);
			// Every other 3x3 window starts right after the previous one
			if (p % 2 == 1)
				gap3[0] = '0;
			fork
				drive_branch(1'b0, 1'b0);
				drive_branch(1'b1, 1'b1);
			join
		end
		@(posedge clk);
		en_3x3 <= 1'b0;

		cycles = 0;
		while (out_count < NPIX) begin
			@(posedge clk);
			cycles++;
			if (cycles > OUT_LIMIT) begin
				$display("timed out waiting for the output pixels of the layer");
				fail_stop();
			end
		end

		cycles = 0;
		while (finish !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > FINISH_LIMIT) begin
				$display("timed out waiting for finish to rise");
				fail_stop();
			end
		end

		// Input past layer end gives no pixel
		gen_pixel(1'b0);
		fork
			drive_branch(1'b0, 1'b0);
			drive_branch(1'b1, 1'b0);
		join
		repeat (20) @(posedge clk);
		check_value("ofm_valid count", 32'(out_count), 32'(NPIX));
		@(negedge clk);
		check_value("finish", 32'(finish), 32'd1);

		// Write-back pulse clears finish for good
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		repeat (10) begin
			@(negedge clk);
			check_value("finish", 32'(finish), 32'd0);
		end

		if (relu_zero_cnt > 0 && relu_pos_cnt > 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("ReLU zero and positive cases were not both exercised");
			fail_stop();
		end
	end

endmodule
